//--- hw/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

    localparam int CSR_ADDR_W = 12;
    localparam int CSR_DATA_W = 32;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;

    // machine mode csrs that exist in storage
    localparam csr_addr_t CSR_NONE     = 12'h000;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;

    // storage index, zero means no register behind the address
    typedef enum logic [2:0] {
        IDX_NONE     = 3'd0,
        IDX_MSCRATCH = 3'd1,
        IDX_MTVEC    = 3'd2,
        IDX_MEPC     = 3'd3,
        IDX_MCAUSE   = 3'd4,
        IDX_MTVAL    = 3'd5
    } csr_idx_t;

    localparam int CSR_COUNT = 5;

    localparam csr_data_t CSR_ALIGN_MASK = 32'hffff_fffc;  // word aligned targets

    // value as the register will hold it
    function automatic csr_data_t csr_legalize(csr_idx_t idx, csr_data_t value);
        if (idx == IDX_MTVEC || idx == IDX_MEPC) begin
            return value & CSR_ALIGN_MASK;
        end
        return value;
    endfunction

endpackage

`default_nettype wire

//--- hw/csr_op_pkg.sv
`default_nettype none

package csr_op_pkg;

    // what the pending write does to the old value
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,   // read only
        OP_WRITE = 2'd1,
        OP_SET   = 2'd2,
        OP_CLEAR = 2'd3
    } csr_op_t;

    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // register forms
    localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;
    localparam logic [2:0] FUNCT3_CSRRS  = 3'b010;
    localparam logic [2:0] FUNCT3_CSRRC  = 3'b011;

    // immediate forms, uimm sits in the rs1 field
    localparam logic [2:0] FUNCT3_CSRRWI = 3'b101;
    localparam logic [2:0] FUNCT3_CSRRSI = 3'b110;
    localparam logic [2:0] FUNCT3_CSRRCI = 3'b111;

    // field positions in the instruction word
    localparam int OPC_LSB       = 0;
    localparam int RD_FIELD_LSB  = 7;
    localparam int FUNCT3_LSB    = 12;
    localparam int RS1_FIELD_LSB = 15;
    localparam int CSR_FIELD_LSB = 20;

endpackage

`default_nettype wire

//--- hw/csr_issue.sv
`timescale 1ns/10ps
`default_nettype none

module csr_issue
    import csr_addr_pkg::*, csr_op_pkg::*;
(
    input  wire            CLK,
    input  wire            rst_n,
    input  wire            in_valid,
    input  wire [31:0]     inst,
    input  wire csr_data_t rs1_data,
    input  wire            stall,
    input  wire            mem_wait,
    input  wire            flush,
    output logic           iss_valid,
    output csr_op_t        iss_op,
    output csr_addr_t      iss_addr,
    output csr_idx_t       iss_idx,
    output csr_data_t      iss_src,
    output logic [4:0]     iss_rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs1_field;
    logic [4:0] rd_field;
    csr_addr_t  csr_field;

    csr_op_t    dec_op;
    csr_idx_t   dec_idx;
    csr_data_t  dec_src;
    logic       dec_csr;
    logic       use_imm;
    logic       advance;

    assign opcode    = inst[OPC_LSB +: 7];
    assign rd_field  = inst[RD_FIELD_LSB +: 5];
    assign funct3    = inst[FUNCT3_LSB +: 3];
    assign rs1_field = inst[RS1_FIELD_LSB +: 5];
    assign csr_field = inst[CSR_FIELD_LSB +: CSR_ADDR_W];

    assign advance = !stall && !mem_wait;

    always_comb begin
        dec_csr = (opcode == OPC_SYSTEM);
        dec_op  = OP_NONE;
        use_imm = 1'b0;
        case (funct3)
            FUNCT3_CSRRW:  dec_op = OP_WRITE;
            FUNCT3_CSRRS:  dec_op = OP_SET;
            FUNCT3_CSRRC:  dec_op = OP_CLEAR;
            FUNCT3_CSRRWI: begin
                dec_op  = OP_WRITE;
                use_imm = 1'b1;
            end
            FUNCT3_CSRRSI: begin
                dec_op  = OP_SET;
                use_imm = 1'b1;
            end
            FUNCT3_CSRRCI: begin
                dec_op  = OP_CLEAR;
                use_imm = 1'b1;
            end
            default:       dec_csr = 1'b0;  // ecall, ebreak, ...
        endcase
        // set or clear from x0 or uimm 0 is a plain read
        if (dec_op != OP_WRITE && rs1_field == 5'd0) begin
            dec_op = OP_NONE;
        end
    end

    always_comb begin
        case (csr_field)
            CSR_MSCRATCH: dec_idx = IDX_MSCRATCH;
            CSR_MTVEC:    dec_idx = IDX_MTVEC;
            CSR_MEPC:     dec_idx = IDX_MEPC;
            CSR_MCAUSE:   dec_idx = IDX_MCAUSE;
            CSR_MTVAL:    dec_idx = IDX_MTVAL;
            default:      dec_idx = IDX_NONE;  // zero or unimplemented
        endcase
    end

    assign dec_src = use_imm ? csr_data_t'(rs1_field) : rs1_data;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
        end else if (flush) begin
            iss_valid <= 1'b0;
        end else if (advance) begin
            iss_valid <= in_valid && dec_csr;
        end
    end

    always_ff @(posedge CLK) begin
        if (advance && in_valid && !flush) begin
            iss_op   <= dec_op;
            iss_addr <= csr_field;
            iss_idx  <= dec_idx;
            iss_src  <= dec_src;
            iss_rd   <= rd_field;
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_forward.sv
`timescale 1ns/10ps
`default_nettype none

module csr_forward
    import csr_addr_pkg::*, csr_op_pkg::*;
(
    input  wire            CLK,
    input  wire            rst_n,
    input  wire            stall,
    input  wire            mem_wait,
    input  wire            flush,
    input  wire            iss_valid,
    input  wire csr_op_t   iss_op,
    input  wire csr_addr_t iss_addr,
    input  wire csr_idx_t  iss_idx,
    input  wire csr_data_t iss_src,
    input  wire [4:0]      iss_rd,
    output csr_idx_t       rf_idx,
    input  wire csr_data_t rf_data,
    output logic           cm_en,
    output csr_idx_t       cm_idx,
    output csr_data_t      cm_data,
    output logic           rd_valid,
    output logic [4:0]     rd_addr,
    output csr_data_t      rd_data,
    output logic           illegal,
    output logic           busy
);

    // exec slot holds the youngest pending write
    logic      ex_en;
    csr_idx_t  ex_idx;
    csr_data_t ex_data;

    // cushion slot drains into the regfile
    logic      cu_en;
    csr_idx_t  cu_idx;
    csr_data_t cu_data;

    logic      held;      // result already shown while stall keeps it in issue

    logic      wr_en;
    csr_data_t old_val;
    csr_data_t new_val;

    assign rf_idx = iss_idx;

    // youngest match wins
    always_comb begin
        if (iss_idx == IDX_NONE) begin
            old_val = '0;
        end else if (ex_en && ex_idx == iss_idx) begin
            old_val = ex_data;
        end else if (cu_en && cu_idx == iss_idx) begin
            old_val = cu_data;
        end else begin
            old_val = rf_data;
        end
    end

    always_comb begin
        case (iss_op)
            OP_WRITE: new_val = iss_src;
            OP_SET:   new_val = old_val | iss_src;
            OP_CLEAR: new_val = old_val & ~iss_src;
            default:  new_val = old_val;
        endcase
    end

    assign wr_en  = iss_valid && iss_op != OP_NONE && iss_idx != IDX_NONE;

    assign rd_valid = iss_valid && !held;
    assign rd_addr  = iss_rd;
    assign rd_data  = old_val;
    assign illegal  = rd_valid && iss_idx == IDX_NONE && iss_addr != CSR_NONE;
    assign busy     = 1'b0;  // flush empties issue too, no slot is ever waited on

    assign cm_en   = cu_en && !mem_wait && !flush;
    assign cm_idx  = cu_idx;
    assign cm_data = cu_data;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            ex_en   <= 1'b0;
            cu_en   <= 1'b0;
            held    <= 1'b0;
        end else if (flush) begin
            ex_en   <= 1'b0;
            cu_en   <= 1'b0;
            held    <= 1'b0;
        end else if (!mem_wait) begin
            ex_en   <= stall ? 1'b0 : wr_en;  // bubble under stall
            cu_en   <= ex_en;
            held    <= stall && (held || rd_valid);
        end
    end

    always_ff @(posedge CLK) begin
        if (!flush && !mem_wait) begin
            ex_idx  <= iss_idx;
            ex_data <= csr_legalize(iss_idx, new_val);
            cu_idx  <= ex_idx;
            cu_data <= ex_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module csr_regfile
    import csr_addr_pkg::*;
(
    input  wire            CLK,
    input  wire            rst_n,
    input  wire csr_idx_t  rf_idx,
    output csr_data_t      rf_data,
    input  wire            cm_en,
    input  wire csr_idx_t  cm_idx,
    input  wire csr_data_t cm_data
);

    csr_data_t  regs [CSR_COUNT];

    logic [2:0] rd_slot;  // index minus one, IDX_NONE wraps out of range
    logic [2:0] wr_slot;
    logic       rd_hit;
    logic       wr_hit;

    assign rd_slot = rf_idx - 3'd1;
    assign wr_slot = cm_idx - 3'd1;

    assign rd_hit = rd_slot < CSR_COUNT;
    assign wr_hit = wr_slot < CSR_COUNT;

    // asynchronous read, zero for anything without storage
    assign rf_data = rd_hit ? regs[rd_slot] : '0;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CSR_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (cm_en && wr_hit) begin
            regs[wr_slot] <= csr_legalize(cm_idx, cm_data);  // mtvec, mepc aligned
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit
    import csr_addr_pkg::*, csr_op_pkg::*;
(
    input  wire            CLK,
    input  wire            rst_n,
    input  wire            in_valid,
    input  wire [31:0]     inst,
    input  wire csr_data_t rs1_data,
    input  wire            stall,
    input  wire            mem_wait,
    input  wire            flush,
    output logic           rd_valid,
    output logic [4:0]     rd_addr,
    output csr_data_t      rd_data,
    output logic           illegal,
    output logic           busy
);

    // issue to forward
    logic       iss_valid;
    csr_op_t    iss_op;
    csr_addr_t  iss_addr;
    csr_idx_t   iss_idx;
    csr_data_t  iss_src;
    logic [4:0] iss_rd;

    // forward to regfile
    csr_idx_t   rf_idx;
    csr_data_t  rf_data;
    logic       cm_en;
    csr_idx_t   cm_idx;
    csr_data_t  cm_data;

    csr_issue u_issue (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .inst      (inst),
        .rs1_data  (rs1_data),
        .stall     (stall),
        .mem_wait  (mem_wait),
        .flush     (flush),
        .iss_valid (iss_valid),
        .iss_op    (iss_op),
        .iss_addr  (iss_addr),
        .iss_idx   (iss_idx),
        .iss_src   (iss_src),
        .iss_rd    (iss_rd)
    );

    csr_forward u_forward (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .stall     (stall),
        .mem_wait  (mem_wait),
        .flush     (flush),
        .iss_valid (iss_valid),
        .iss_op    (iss_op),
        .iss_addr  (iss_addr),
        .iss_idx   (iss_idx),
        .iss_src   (iss_src),
        .iss_rd    (iss_rd),
        .rf_idx    (rf_idx),
        .rf_data   (rf_data),
        .cm_en     (cm_en),
        .cm_idx    (cm_idx),
        .cm_data   (cm_data),
        .rd_valid  (rd_valid),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .illegal   (illegal),
        .busy      (busy)
    );

    csr_regfile u_regfile (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .rf_idx    (rf_idx),
        .rf_data   (rf_data),
        .cm_en     (cm_en),
        .cm_idx    (cm_idx),
        .cm_data   (cm_data)
    );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic CLK,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 2;   // 4 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;  // release away from the rising edge
    end

endmodule

`default_nettype wire

//--- test/tb_csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_csr_unit
    import csr_addr_pkg::*, csr_op_pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int CYCLES_PER_OP = 20;  // watchdog budget per entry

    logic        CLK;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] inst;
    csr_data_t   rs1_data;
    logic        stall;
    logic        mem_wait;
    logic        flush;
    logic        rd_valid;
    logic [4:0]  rd_addr;
    csr_data_t   rd_data;
    logic        illegal;
    logic        busy;

    logic [31:0] tbl_inst [$];
    csr_data_t   tbl_src [$];
    csr_data_t   tbl_old [$];   // expected rd_data
    logic        tbl_ill [$];
    logic [4:0]  tbl_rd [$];
    logic        tbl_drop [$];  // flushed while in issue
    logic        table_ready;

    logic [31:0] lfsr;
    logic        add_stall;
    logic        add_wait;
    int          watchdog_ns;

    tb_clock u_clock (
        .CLK   (CLK),
        .rst_n (rst_n)
    );

    csr_unit DUT (.*);

    function automatic logic [31:0] step_lfsr(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
        end
        return state >> 1;
    endfunction

    task automatic add_entry(input logic [2:0] funct3, input csr_addr_t addr,
                             input logic [4:0] src_field, input logic [4:0] rd,
                             input csr_data_t src, input csr_data_t old_val,
                             input logic ill, input logic drop);
        tbl_inst.push_back({addr, src_field, funct3, rd, OPC_SYSTEM});
        tbl_src.push_back(src);
        tbl_old.push_back(old_val);
        tbl_ill.push_back(ill);
        tbl_rd.push_back(rd);
        tbl_drop.push_back(drop);
    endtask

    task automatic check_data(input csr_data_t got, input csr_data_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_rd(input logic [4:0] got, input logic [4:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic fill_table();
        // op, csr, source field, rd, rs1_data, expected old value, illegal, flushed
        add_entry(FUNCT3_CSRRW, CSR_MSCRATCH, 5'd1, 5'd5, 32'hdead_beef, 32'h0000_0000, 0, 0);
        add_entry(FUNCT3_CSRRW, CSR_MTVEC, 5'd2, 5'd6, 32'h8000_0103, 32'h0000_0000, 0, 0);
        add_entry(FUNCT3_CSRRW, CSR_MEPC, 5'd3, 5'd7, 32'h0000_1237, 32'h0000_0000, 0, 0);
        add_entry(FUNCT3_CSRRW, CSR_MCAUSE, 5'd4, 5'd8, 32'h8000_000b, 32'h0000_0000, 0, 0);
        add_entry(FUNCT3_CSRRW, CSR_MTVAL, 5'd5, 5'd9, 32'hcafe_f00d, 32'h0000_0000, 0, 0);
        add_entry(FUNCT3_CSRRS, CSR_MTVEC, 5'd0, 5'd10, 32'h0000_00ff, 32'h8000_0100, 0, 0);
        add_entry(FUNCT3_CSRRS, CSR_MEPC, 5'd0, 5'd11, 32'h0000_0000, 32'h0000_1234, 0, 0);
        // back to back read-modify-write on mscratch
        add_entry(FUNCT3_CSRRS, CSR_MSCRATCH, 5'd6, 5'd12, 32'h0000_00ff, 32'hdead_beef, 0, 0);
        add_entry(FUNCT3_CSRRC, CSR_MSCRATCH, 5'd7, 5'd13, 32'hffff_0000, 32'hdead_beff, 0, 0);
        add_entry(FUNCT3_CSRRS, CSR_MCAUSE, 5'd0, 5'd14, 32'h0000_0000, 32'h8000_000b, 0, 0);
        add_entry(FUNCT3_CSRRS, CSR_MSCRATCH, 5'd8, 5'd15, 32'h1000_0000, 32'h0000_beff, 0, 0);
        add_entry(FUNCT3_CSRRC, CSR_MCAUSE, 5'd9, 5'd16, 32'h8000_0000, 32'h8000_000b, 0, 0);
        add_entry(FUNCT3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd17, 32'hffff_0000, 32'h1000_beff, 0, 0);
        // immediate forms ignore rs1_data
        add_entry(FUNCT3_CSRRWI, CSR_MTVAL, 5'h1f, 5'd19, 32'hffff_ffff, 32'hcafe_f00d, 0, 0);
        add_entry(FUNCT3_CSRRSI, CSR_MTVAL, 5'h00, 5'd20, 32'hffff_ffff, 32'h0000_001f, 0, 0);
        add_entry(FUNCT3_CSRRCI, CSR_MTVAL, 5'h05, 5'd21, 32'hffff_ffff, 32'h0000_001f, 0, 0);
        add_entry(FUNCT3_CSRRSI, CSR_MEPC, 5'h13, 5'd22, 32'h0000_0000, 32'h0000_1234, 0, 0);
        add_entry(FUNCT3_CSRRS, CSR_MTVAL, 5'd0, 5'd23, 32'h0000_0000, 32'h0000_001a, 0, 0);
        // address zero then mstatus and mip without storage
        add_entry(FUNCT3_CSRRW, CSR_NONE, 5'd10, 5'd24, 32'h1234_5678, 32'h0000_0000, 0, 0);
        add_entry(FUNCT3_CSRRW, 12'h300, 5'd11, 5'd26, 32'hffff_ffff, 32'h0000_0000, 1, 0);
        add_entry(FUNCT3_CSRRS, 12'h344, 5'd0, 5'd27, 32'h0000_0000, 32'h0000_0000, 1, 0);
        add_entry(FUNCT3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd28, 32'h0000_0000, 32'h1000_beff, 0, 0);
        // flushed writes must leave no trace
        add_entry(FUNCT3_CSRRW, CSR_MSCRATCH, 5'd12, 5'd29, 32'h0bad_0bad, 32'h1000_beff, 0, 1);
        add_entry(FUNCT3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd30, 32'h0000_0000, 32'h1000_beff, 0, 0);
        add_entry(FUNCT3_CSRRS, CSR_MTVEC, 5'd13, 5'd31, 32'h0000_00ff, 32'h8000_0100, 0, 1);
        add_entry(FUNCT3_CSRRW, CSR_MTVEC, 5'd14, 5'd1, 32'h0000_4000, 32'h8000_0100, 0, 0);
        add_entry(FUNCT3_CSRRS, CSR_MTVEC, 5'd0, 5'd2, 32'h0000_0000, 32'h0000_4000, 0, 0);
    endtask

    initial begin
        in_valid    = 1'b0;
        inst        = '0;
        rs1_data    = '0;
        stall       = 1'b0;
        mem_wait    = 1'b0;
        flush       = 1'b0;
        lfsr        = 32'h43b7_dada;
        table_ready = 1'b0;
        fill_table();
        table_ready = 1'b1;
        @(posedge rst_n);
        @(negedge CLK);
        for (int i = 0; i < tbl_inst.size(); i++) begin
            lfsr      = step_lfsr(lfsr);
            add_stall = lfsr[0];
            lfsr      = step_lfsr(lfsr);
            add_wait  = lfsr[0];
            if (tbl_drop[i]) begin
                repeat (3) @(negedge CLK);  // let pending writes commit
            end
            in_valid = 1'b1;
            inst     = tbl_inst[i];
            rs1_data = tbl_src[i];
            stall    = add_stall;
            mem_wait = add_wait;
            if (add_stall || add_wait) begin
                @(negedge CLK);
                stall    = 1'b0;
                mem_wait = 1'b0;
            end
            @(negedge CLK);  // captured at the edge just passed
            in_valid = 1'b0;
            if (tbl_drop[i]) begin
                flush = 1'b1;
                @(negedge CLK);
                flush = 1'b0;
                check_flag(rd_valid, 1'b0, $sformatf("entry %0d rd_valid after flush", i));
                check_flag(busy, 1'b0, $sformatf("entry %0d busy after flush", i));
            end else begin
                while (!rd_valid) begin
                    @(negedge CLK);
                end
                check_flag(busy, 1'b0, $sformatf("entry %0d busy", i));
                check_rd(rd_addr, tbl_rd[i], $sformatf("entry %0d rd_addr", i));
                check_data(rd_data, tbl_old[i], $sformatf("entry %0d rd_data", i));
                check_flag(illegal, tbl_ill[i], $sformatf("entry %0d illegal", i));
            end
        end
        $display("test passed");
        $finish;
    end

    initial begin
        wait (table_ready);
        watchdog_ns = tbl_inst.size() * CYCLES_PER_OP * CLK_PERIOD;
        #(watchdog_ns);
        $display("Timeout after %0d ns because the DUT never produced a result", watchdog_ns);
        $display("test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- build.f
hw/csr_addr_pkg.sv
hw/csr_op_pkg.sv
hw/csr_issue.sv
hw/csr_forward.sv
hw/csr_regfile.sv
hw/csr_unit.sv
test/tb_clock.sv
test/tb_csr_unit.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - files:
      - hw/csr_addr_pkg.sv
      - hw/csr_op_pkg.sv
      - hw/csr_issue.sv
      - hw/csr_forward.sv
      - hw/csr_regfile.sv
      - hw/csr_unit.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_csr_unit.sv
